// ==== logic/fetch_pkg.sv ====
/*
 * fetch side definitions for the re-aligner
 * address width, fetch block and parcel widths, parcel count,
 * address and parcel types, and the fetch request struct
 */
package fetch_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // virtual address width of the core, fixed for this fetch path
    localparam int unsigned VLEN = 32;
    // one fetch delivers a full 64-bit block from the cache
    localparam int unsigned FETCH_WIDTH = 64;
    // a parcel is one 16-bit halfword, the smallest instruction granule
    localparam int unsigned PARCEL_WIDTH = 16;
    // number of halfwords in one fetch block
    localparam int unsigned PARCELS_PER_FETCH = FETCH_WIDTH / PARCEL_WIDTH;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    typedef logic [VLEN-1:0] vaddr_t;
    typedef logic [PARCEL_WIDTH-1:0] parcel_t;
    typedef logic [FETCH_WIDTH-1:0] fetch_data_t;
    // selects one parcel inside a fetch block, this is address bits 2:1
    typedef logic [$clog2(PARCELS_PER_FETCH)-1:0] parcel_idx_t;

    // one fetch as seen by the re-aligner
    // addr may point at any halfword, the block itself is always 8-byte aligned
    typedef struct packed {
        logic        valid;
        vaddr_t      addr;
        fetch_data_t data;
    } fetch_req_t;

endpackage

// ==== logic/instr_pkg.sv ====
/*
 * instruction side definitions for the re-aligner
 * instruction word, output slot and slot array, carry register
 * contents and the scan result passed from scanner to packer
 */
package instr_pkg;

    // every parcel can start at most one instruction, so four slots suffice
    localparam int unsigned INSTR_PER_FETCH = fetch_pkg::PARCELS_PER_FETCH;

    // both low opcode bits set means the parcel opens a 32-bit instruction
    localparam logic [1:0] RVC_OPCODE_FULL = 2'b11;

    // a compressed instruction sits in the low half with zeros above it
    typedef logic [31:0] instr_t;

    // one output slot with its own program counter
    typedef struct packed {
        logic               valid;
        fetch_pkg::vaddr_t  addr;
        instr_t             instr;
    } instr_slot_t;

    // slot 0 is the oldest instruction of the fetch
    typedef instr_slot_t [INSTR_PER_FETCH-1:0] slot_array_t;

    // lower half of a 32-bit instruction that began in the last parcel
    // addr is the address of that lower half, so it always ends in 110
    typedef struct packed {
        logic               valid;
        fetch_pkg::parcel_t parcel;
        fetch_pkg::vaddr_t  addr;
    } carry_t;

    // where instructions start inside the current fetch
    typedef struct packed {
        logic [fetch_pkg::PARCELS_PER_FETCH-1:0] start_mask;
        logic [fetch_pkg::PARCELS_PER_FETCH-1:0] wide_mask;
        logic                                    carry_done;
        logic                                    split_last;
    } scan_t;

endpackage

// ==== logic/parcel_scanner.sv ====
/*
 * parcel scanner of the re-aligner
 * walks the four parcels of a fetch and marks every instruction start,
 * flags 32-bit starts and reports a 32-bit start in the last parcel
 */
`timescale 1ns/1ps

module parcel_scanner (
    input  fetch_pkg::fetch_req_t fetch_i,
    input  instr_pkg::carry_t     carry_i,
    output instr_pkg::scan_t      scan_o
);

    // set for each parcel whose opcode bits mark a 32-bit instruction
    logic [fetch_pkg::PARCELS_PER_FETCH-1:0] is_full;
    // parcel where the walk begins, one bit wider than a parcel index
    logic [2:0] first_parcel;

    // ------------------------------------------------------------------------
    // opcode decode
    // ------------------------------------------------------------------------

    // a parcel is only meaningful as a start if the walk lands on it
    // the decode itself is done for all of them in parallel
    for (genvar p = 0; p < fetch_pkg::PARCELS_PER_FETCH; p++) begin : g_opcode
        assign is_full[p] =
            (fetch_i.data[p*fetch_pkg::PARCEL_WIDTH +: 2] == instr_pkg::RVC_OPCODE_FULL);
    end

    // ------------------------------------------------------------------------
    // start parcel
    // ------------------------------------------------------------------------

    // with a carry held, parcel 0 is the upper half of the carried
    // instruction and the first new instruction begins at parcel 1
    // a fetch after a carry is sequential, so address bits 2:1 are zero
    // anyway and are not looked at
    // without a carry the fetch address may point into the middle of
    // the block, e.g. after a branch to an odd halfword
    assign first_parcel = carry_i.valid ? 3'd1 : {1'b0, fetch_i.addr[2:1]};

    // ------------------------------------------------------------------------
    // parcel walk
    // ------------------------------------------------------------------------

    always_comb begin : walk
        // next parcel that is known to begin an instruction
        // it can run past the block by up to two parcels
        logic [2:0] next_start;

        scan_o     = '0;
        next_start = first_parcel;

        if (fetch_i.valid) begin
            // the carried lower half is finished by parcel 0 of this fetch
            scan_o.carry_done = carry_i.valid;

            // parcels below the start pointer are either before the
            // entry address or belong to the previous instruction
            for (int i = 0; i < fetch_pkg::PARCELS_PER_FETCH; i++) begin
                if (next_start == 3'(i)) begin
                    scan_o.start_mask[i] = 1'b1;
                    scan_o.wide_mask[i]  = is_full[i];
                    // a 32-bit instruction covers this parcel and the next
                    if (is_full[i]) begin
                        next_start = next_start + 3'd2;
                    end else begin
                        next_start = next_start + 3'd1;
                    end
                end
            end

            // a 32-bit start in the top parcel has its upper half in the
            // next fetch, the carry buffer keeps the lower half until then
            scan_o.split_last = scan_o.wide_mask[fetch_pkg::PARCELS_PER_FETCH-1];
        end
    end

endmodule

// ==== logic/carry_buffer.sv ====
/*
 * carry register of the re-aligner
 * keeps the lower half and the address of a 32-bit instruction that
 * was split across two fetches, cleared by reset and flush
 */
`timescale 1ns/1ps

module carry_buffer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  fetch_pkg::fetch_req_t fetch_i,
    input  logic                  split_last_i,
    output instr_pkg::carry_t     carry_o
);

    logic               carry_valid_q;
    fetch_pkg::parcel_t carry_parcel_q;
    fetch_pkg::vaddr_t  carry_addr_q;

    // every valid fetch decides again whether a half is left over
    // a flush drops it, also when the same fetch would have split
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            carry_valid_q <= 1'b0;
        end else if (flush_i) begin
            carry_valid_q <= 1'b0;
        end else if (fetch_i.valid) begin
            carry_valid_q <= split_last_i;
        end
    end

    // the split half is always parcel 3, at offset 6 inside the block
    always_ff @(posedge clk_i) begin
        if (fetch_i.valid && split_last_i) begin
            carry_parcel_q <= fetch_i.data[(fetch_pkg::PARCELS_PER_FETCH-1) *
                                           fetch_pkg::PARCEL_WIDTH +: fetch_pkg::PARCEL_WIDTH];
            carry_addr_q   <= {fetch_i.addr[fetch_pkg::VLEN-1:3], 3'b110};
        end
    end

    assign carry_o = '{valid: carry_valid_q, parcel: carry_parcel_q, addr: carry_addr_q};

    // ------------------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------------------

    // a redirect must never complete a stale lower half
    flush_drops_carry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !carry_valid_q)
        else $error("carry still valid one cycle after flush");

    // the held half must survive idle cycles untouched
    payload_on_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$stable({carry_parcel_q, carry_addr_q}) |-> $past(fetch_i.valid))
        else $error("carry payload changed without a valid fetch");

    // only the top parcel of a block can be left over
    carry_addr_top: assert property (@(posedge clk_i) disable iff (!rst_ni)
        carry_valid_q |-> (carry_addr_q[2:0] == 3'b110))
        else $error("held carry address does not end in 110");

endmodule

// ==== logic/slot_packer.sv ====
/*
 * slot packer of the re-aligner
 * assembles instructions from the scan marks, the fetch data and the
 * carry, and packs them into consecutive output slots from slot 0
 */
`timescale 1ns/1ps

module slot_packer (
    input  fetch_pkg::fetch_req_t  fetch_i,
    input  instr_pkg::carry_t      carry_i,
    input  instr_pkg::scan_t       scan_i,
    output instr_pkg::slot_array_t slots_o
);

    // fetch block with one zero parcel on top, so that the upper half of a
    // start at parcel 3 can be selected like any other
    logic [fetch_pkg::FETCH_WIDTH+fetch_pkg::PARCEL_WIDTH-1:0] data_ext;
    // slot valid bits gathered for the contiguity check
    logic [instr_pkg::INSTR_PER_FETCH-1:0] slot_valid;

    assign data_ext = {{fetch_pkg::PARCEL_WIDTH{1'b0}}, fetch_i.data};

    // ------------------------------------------------------------------------
    // instruction assembly and compaction
    // ------------------------------------------------------------------------

    always_comb begin : pack
        // next free output slot
        logic [$clog2(instr_pkg::INSTR_PER_FETCH)-1:0] fill;
        fetch_pkg::parcel_t lo_parcel;
        fetch_pkg::parcel_t hi_parcel;

        slots_o = '0;
        fill    = '0;

        // the instruction finished by parcel 0 is older than anything
        // that starts in this block, so it takes slot 0
        if (scan_i.carry_done) begin
            slots_o[0].valid = 1'b1;
            slots_o[0].addr  = carry_i.addr;
            slots_o[0].instr = {data_ext[fetch_pkg::PARCEL_WIDTH-1:0], carry_i.parcel};
            fill             = fill + 1'b1;
        end

        // starts are taken in parcel order, which is program order
        for (int i = 0; i < fetch_pkg::PARCELS_PER_FETCH; i++) begin
            lo_parcel = data_ext[i*fetch_pkg::PARCEL_WIDTH +: fetch_pkg::PARCEL_WIDTH];
            hi_parcel = data_ext[(i+1)*fetch_pkg::PARCEL_WIDTH +: fetch_pkg::PARCEL_WIDTH];

            // a 32-bit start in the top parcel has no upper half yet
            // it comes out with the next fetch through the carry
            if (scan_i.start_mask[i] &&
                !(i == fetch_pkg::PARCELS_PER_FETCH-1 && scan_i.wide_mask[i])) begin
                slots_o[fill].valid = 1'b1;
                // pc of the start parcel, the block base plus twice the index
                slots_o[fill].addr  = {fetch_i.addr[fetch_pkg::VLEN-1:3],
                                       fetch_pkg::parcel_idx_t'(i), 1'b0};
                if (scan_i.wide_mask[i]) begin
                    slots_o[fill].instr = {hi_parcel, lo_parcel};
                end else begin
                    slots_o[fill].instr = {{fetch_pkg::PARCEL_WIDTH{1'b0}}, lo_parcel};
                end
                fill = fill + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------------------

    for (genvar k = 0; k < instr_pkg::INSTR_PER_FETCH; k++) begin : g_valid
        assign slot_valid[k] = slots_o[k].valid;
    end

    // the decode stage reads slots from 0 upward and stops at the first hole
    // so a valid slot above an invalid one would be lost
    always_comb begin : check_contiguous
        slots_contiguous: assert #0 ((slot_valid & (slot_valid + 1'b1)) == '0)
            else $error("slot valids are not contiguous from slot 0");
    end

endmodule

// ==== logic/instr_realign_top.sv ====
/*
 * top level of the instruction re-aligner
 * connects the parcel scanner, the carry buffer and the slot packer
 */
`timescale 1ns/1ps

module instr_realign_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  fetch_pkg::fetch_req_t  fetch_i,
    output instr_pkg::slot_array_t slots_o,
    output logic                   serving_unaligned_o
);

    // held lower half, read by the scanner to shift the walk and by the
    // packer to build slot 0
    instr_pkg::carry_t carry;
    // start marks of the current fetch
    instr_pkg::scan_t  scan;

    // ------------------------------------------------------------------------
    // instances
    // ------------------------------------------------------------------------

    parcel_scanner parcel_scanner_inst (
        .fetch_i (fetch_i),
        .carry_i (carry),
        .scan_o  (scan)
    );

    // only the split flag of the scan result reaches the register
    carry_buffer carry_buffer_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fetch_i      (fetch_i),
        .split_last_i (scan.split_last),
        .carry_o      (carry)
    );

    // fetch to slots is purely combinational
    slot_packer slot_packer_inst (
        .fetch_i (fetch_i),
        .carry_i (carry),
        .scan_i  (scan),
        .slots_o (slots_o)
    );

    // slot 0 of the next fetch will be an instruction that began earlier
    assign serving_unaligned_o = carry.valid;

endmodule

// ==== tb/realign_checker.sv ====
/*
 * reference model and checker for the re-aligner
 * walks every fetch on its own, keeps its own carry state and
 * compares all output slots and the carry flag with concurrent assertions
 */
`timescale 1ns/1ps

module realign_checker (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  fetch_pkg::fetch_req_t  fetch_i,
    input  instr_pkg::slot_array_t slots_i,
    input  logic                   serving_unaligned_i
);

    // expected slots for the fetch that is on the bus right now
    instr_pkg::slot_array_t exp_slots;
    // the expected walk ends on a 32-bit start in the top parcel
    logic                   exp_split;

    // model copy of the carry register
    logic                   carry_valid_m;
    fetch_pkg::parcel_t     carry_parcel_m;
    fetch_pkg::vaddr_t      carry_addr_m;

    // ------------------------------------------------------------------------
    // reference walk
    // ------------------------------------------------------------------------

    // pos steps through the halfwords of the block like a program counter
    always_comb begin : reference_walk
        fetch_pkg::vaddr_t  base;
        fetch_pkg::parcel_t lo;
        int                 pos;
        int                 n;

        exp_slots = '0;
        exp_split = 1'b0;
        base      = {fetch_i.addr[31:3], 3'b000};
        pos       = 4;
        n         = 0;

        if (fetch_i.valid) begin
            if (carry_valid_m) begin
                // parcel 0 is the upper half of the held instruction
                exp_slots[0].valid = 1'b1;
                exp_slots[0].addr  = carry_addr_m;
                exp_slots[0].instr = {fetch_i.data[15:0], carry_parcel_m};
                n   = 1;
                pos = 1;
            end else begin
                pos = int'(fetch_i.addr[2:1]);
            end

            while (pos < 4) begin
                lo = fetch_i.data[pos*16 +: 16];
                if (lo[1:0] != 2'b11) begin
                    exp_slots[n].valid = 1'b1;
                    exp_slots[n].addr  = base + 32'(2 * pos);
                    exp_slots[n].instr = {16'h0000, lo};
                    n   = n + 1;
                    pos = pos + 1;
                end else if (pos == 3) begin
                    // upper half lives in the next block
                    exp_split = 1'b1;
                    pos       = 4;
                end else begin
                    exp_slots[n].valid = 1'b1;
                    exp_slots[n].addr  = base + 32'(2 * pos);
                    exp_slots[n].instr = {fetch_i.data[(pos+1)*16 +: 16], lo};
                    n   = n + 1;
                    pos = pos + 2;
                end
            end
        end
    end

    // carry state follows the same rules as the hardware register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            carry_valid_m  <= 1'b0;
            carry_parcel_m <= '0;
            carry_addr_m   <= '0;
        end else begin
            if (flush_i) begin
                carry_valid_m <= 1'b0;
            end else if (fetch_i.valid) begin
                carry_valid_m <= exp_split;
            end
            if (fetch_i.valid && exp_split) begin
                carry_parcel_m <= fetch_i.data[63:48];
                carry_addr_m   <= {fetch_i.addr[31:3], 3'b000} + 32'd6;
            end
        end
    end

    // ------------------------------------------------------------------------
    // output checks
    // ------------------------------------------------------------------------

    for (genvar k = 0; k < 4; k++) begin : g_slot
        slot_valid_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
            slots_i[k].valid == exp_slots[k].valid)
            else tb_instr_realign.report_mismatch($sformatf("slots_o[%0d].valid", k),
                64'($sampled(exp_slots[k].valid)), 64'($sampled(slots_i[k].valid)));

        slot_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
            slots_i[k].addr == exp_slots[k].addr)
            else tb_instr_realign.report_mismatch($sformatf("slots_o[%0d].addr", k),
                64'($sampled(exp_slots[k].addr)), 64'($sampled(slots_i[k].addr)));

        slot_instr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
            slots_i[k].instr == exp_slots[k].instr)
            else tb_instr_realign.report_mismatch($sformatf("slots_o[%0d].instr", k),
                64'($sampled(exp_slots[k].instr)), 64'($sampled(slots_i[k].instr)));
    end

    // the flag must track the model carry in every cycle, idle ones too
    serving_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        serving_unaligned_i == carry_valid_m)
        else tb_instr_realign.report_mismatch("serving_unaligned_o",
            64'($sampled(carry_valid_m)), 64'($sampled(serving_unaligned_i)));

endmodule

// ==== tb/tb_instr_realign.sv ====
/*
 * testbench for the instruction re-aligner
 * clock and reset, directed fetches, a seeded random instruction
 * stream with redirects, a cycle limit and the final verdict
 */
`timescale 1ns/1ps

module tb_instr_realign;

    // directed part plus random part stay below this many cycles
    localparam int unsigned STIM_CYCLES    = 2000;
    localparam int unsigned RANDOM_CYCLES  = 1900;
    localparam int unsigned TIMEOUT_CYCLES = STIM_CYCLES + 100;

    logic                   clk;
    logic                   rst_n;
    logic                   flush;
    fetch_pkg::fetch_req_t  fetch;
    instr_pkg::slot_array_t slots;
    logic                   serving_unaligned;

    int unsigned            cycle_count;
    // parcels of the instruction stream not yet placed in a fetch
    fetch_pkg::parcel_t     stream_q[$];

    instr_realign_top instr_realign_top_inst (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .flush_i             (flush),
        .fetch_i             (fetch),
        .slots_o             (slots),
        .serving_unaligned_o (serving_unaligned)
    );

    realign_checker realign_checker_inst (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .flush_i             (flush),
        .fetch_i             (fetch),
        .slots_i             (slots),
        .serving_unaligned_i (serving_unaligned)
    );

    always #4 clk = ~clk;

    // hard stop in case the stimulus never reaches its end
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    // called by the checker at its first mismatch
    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error at %0t ns: %s expected 0x%0h got 0x%0h", $time, name,
                 expected, actual);
        $display("TEST FAIL");
        $fatal(1, "stopping on first mismatch");
    endtask

    // new inputs settle 1 ns after the edge and hold for the whole cycle
    task automatic apply_fetch(input logic do_flush, input logic valid,
                               input fetch_pkg::vaddr_t addr, input fetch_pkg::fetch_data_t data);
        @(posedge clk);
        #1;
        flush = do_flush;
        fetch = '{valid: valid, addr: addr, data: data};
    endtask

    // takes the next parcel of the stream and makes up a new instruction
    // when the stream has run dry, about 40 % of them compressed
    function automatic fetch_pkg::parcel_t next_parcel();
        fetch_pkg::parcel_t lo;

        if (stream_q.size() == 0) begin
            lo = 16'($urandom);
            if ($urandom_range(9) < 4) begin
                lo[1:0] = 2'($urandom_range(2));
                stream_q.push_back(lo);
            end else begin
                lo[1:0] = 2'b11;
                stream_q.push_back(lo);
                stream_q.push_back(16'($urandom));
            end
        end
        return stream_q.pop_front();
    endfunction

    // one block of the stream at pc
    // parcels before the entry point are junk the walk skips
    function automatic fetch_pkg::fetch_data_t build_block(input fetch_pkg::vaddr_t pc);
        fetch_pkg::fetch_data_t data;

        for (int p = 0; p < 4; p++) begin
            if (p < int'(pc[2:1])) begin
                data[p*16 +: 16] = 16'($urandom);
            end else begin
                data[p*16 +: 16] = next_parcel();
            end
        end
        return data;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    initial begin
        fetch_pkg::vaddr_t pc;

        void'($urandom(63106));
        clk         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        fetch       = '0;
        cycle_count = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset, no slot and no carry
        apply_fetch(1'b0, 1'b0, '0, '0);
        // four compressed parcels from an aligned block
        apply_fetch(1'b0, 1'b1, 32'h1000, {16'h00c1, 16'h0080, 16'h0042, 16'h0001});
        // 32-bit start in parcel 3, held across an idle cycle
        apply_fetch(1'b0, 1'b1, 32'h1008, {16'h1233, 16'h0000, 16'h0002, 16'h0001});
        apply_fetch(1'b0, 1'b0, '0, '0);
        apply_fetch(1'b0, 1'b1, 32'h1010, {16'h0005, 16'h0004, 16'h0009, 16'habcd});
        // redirect into parcel 3 which opens a 32-bit instruction
        apply_fetch(1'b1, 1'b0, '0, '0);
        apply_fetch(1'b0, 1'b1, 32'h2006, {16'h5673, 16'h1111, 16'h2222, 16'h3333});
        // flush drops that carry, the compressed redirect gives one slot
        apply_fetch(1'b1, 1'b0, '0, '0);
        apply_fetch(1'b0, 1'b1, 32'h3006, {16'h4562, 16'h7777, 16'h8888, 16'h9999});
        // entry at parcel 1 with a 32-bit instruction in parcels 1 and 2
        apply_fetch(1'b0, 1'b1, 32'h4002, {16'h0001, 16'hbeef, 16'h0013, 16'hffff});

        // random sequential stream, restarted now and then by a redirect
        stream_q.delete();
        pc = $urandom & 32'hffff_fffe;
        apply_fetch(1'b1, 1'b0, '0, '0);
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            if ($urandom_range(15) == 0) begin
                // the flush sometimes comes with a last fetch of the old
                // stream, and a split in that fetch must not be kept
                apply_fetch(1'b1, 1'($urandom_range(1)), pc, build_block(pc));
                stream_q.delete();
                pc = $urandom & 32'hffff_fffe;
            end else if ($urandom_range(4) == 0) begin
                apply_fetch(1'b0, 1'b0, pc, '0);
            end else begin
                apply_fetch(1'b0, 1'b1, pc, build_block(pc));
                pc = {pc[31:3], 3'b000} + 32'd8;
            end
        end

        // let the checker see the last fetch before the verdict
        apply_fetch(1'b0, 1'b0, '0, '0);
        repeat (2) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/fetch_pkg.sv
logic/instr_pkg.sv
logic/parcel_scanner.sv
logic/carry_buffer.sv
logic/slot_packer.sv
logic/instr_realign_top.sv
tb/realign_checker.sv
tb/tb_instr_realign.sv
